// ==== Bender.yml ====
package:
  name: memory_game

sources:
  - include_dirs:
      - hw
    files:
      - hw/game_pkg.sv
      - hw/disp_pkg.sv
      - hw/target_gen.sv
      - hw/target_fifo.sv
      - hw/round_ctrl.sv
      - hw/seg_scan.sv
      - hw/memory_game_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/tb_memory_game.sv

// ==== compile.f ====
+incdir+hw
hw/game_pkg.sv
hw/disp_pkg.sv
hw/target_gen.sv
hw/target_fifo.sv
hw/round_ctrl.sv
hw/seg_scan.sv
hw/memory_game_top.sv
dv/tb_memory_game.sv

// ==== dv/game_vectors.txt ====
# columns: name op arg round status
# op: off, rst, hit, flip, rhi, rlo; arg in hex; round and status (s show, p win) expected after
power_on          off  0c 1 s
r1_hit            hit  00 2 s
r2_miss           flip 01 2 s
r2_hit_high       flip 40 3 s
r3_miss           flip 40 3 s
r3_win            hit  00 3 p
win_restart       rst  00 1 s
r1_rand_high      rhi  00 2 s
r2_rand_low       rlo  00 2 s
r2_rand_high      rhi  00 3 s
r3_rand_low       rlo  00 3 s
long_wait_restart rst  28 1 s
r1_miss           flip 10 1 s
r1_hit_high       flip 60 2 s
mid_game_off      off  0c 1 s
r1_hit_again      hit  00 2 s
r2_hit_again      hit  00 3 s
r3_win_again      hit  00 3 p
win_wait_restart  rst  14 1 s

// ==== dv/tb_memory_game.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module tb_memory_game;

    import game_pkg::*;
    import disp_pkg::*;

    logic                      clk;
    logic                      sw;
    logic                      enable;
    logic                      start;
    logic                      restart;
    logic [`GAME_TARGET_W-1:0] guess;
    logic [15:0]               led;
    seg_t                      seg;
    logic [7:0]                dig;

    string       v_name[$];
    string       v_op[$];
    string       v_stat[$];
    int          v_arg[$];
    int          v_round[$];
    logic [15:0] ref_lfsr;
    logic [31:0] rnd_lfsr;
    logic [6:0]  cur_target;
    int          cur_round;
    string       cur_name;
    int          test_errors;
    int          passed;
    int          failed;
    int          cycles;
    int          cycle_limit;

    memory_game_top UUT (
        .clk     (clk),
        .sw      (sw),
        .enable  (enable),
        .start   (start),
        .restart (restart),
        .guess   (guess),
        .led     (led),
        .seg     (seg),
        .dig     (dig)
    );

    always #5 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("timeout after %0d cycles, the game stopped advancing", cycles);
            $display("TEST FAIL");
            $finish;
        end
    end

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr16_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr32_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // 5, 6 or 7 bits for rounds 1 to 3
    function automatic logic [6:0] width_mask(input int r);
        return 7'((1 << (4 + r)) - 1);
    endfunction

    task automatic check_val(input string what, input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp)
        else
        begin
            $display("Fail %s %s: expected %h, actual %h", cur_name, what, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond)
        else
        begin
            $display("%s: %s", cur_name, msg);
            test_errors++;
        end
    endtask

    task automatic check_display(input seg_t letter);
        if (dig == 8'b1111_1110)
            check_val("round digit", SEG_DIGIT[cur_round], seg);
        else if (dig == 8'b1111_1101)
            check_val("status digit", letter, seg);
        else
            check_true(1'b0, "display does not select exactly one digit");
    endtask

    task automatic take_target();
        cur_target = ref_lfsr[6:0];
        ref_lfsr   = lfsr16_next(ref_lfsr);
    endtask

    // one lfsr step per random bit
    task automatic draw_bits(input int n, output logic [6:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            rnd_lfsr = lfsr32_next(rnd_lfsr);
            v = {v[5:0], rnd_lfsr[0]};
        end
    endtask

    task automatic pulse_start(input logic [6:0] g);
        guess = g;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    // whole show window, then a full scan of the wait display
    task automatic watch_show();
        int          n;
        logic [15:0] exp_led;
        n = 0;
        exp_led = {9'd0, cur_target & width_mask(cur_round)};
        while (UUT.u_round_ctrl.state != SHOW)
            @(negedge clk);
        while (UUT.u_round_ctrl.state == SHOW)
        begin
            check_val("show led", exp_led, led);
            check_display(SEG_S);
            n++;
            @(negedge clk);
        end
        check_val("show length", `GAME_SHOW_CYCLES, n);
        check_true(UUT.u_round_ctrl.state == WAIT, "game left SHOW for a state other than WAIT");
        repeat (2 * `GAME_SCAN_DIV)
        begin
            check_val("wait led", 16'h0, led);
            check_display(SEG_G);
            @(negedge clk);
        end
    endtask

    task automatic watch_win();
        while (UUT.u_round_ctrl.state != WIN)
            @(negedge clk);
        repeat (2 * `GAME_SCAN_DIV)
        begin
            check_val("win led", `GAME_WIN_LED, led);
            check_display(SEG_P);
            @(negedge clk);
        end
    endtask

    task automatic run_test(input int i);
        logic [6:0] flip;
        logic       hit;
        cur_name    = v_name[i];
        test_errors = 0;
        flip        = '0;
        hit         = 1'b0;
        if (v_op[i] == "off")
        begin
            enable = 1'b0;
            while (UUT.u_round_ctrl.state != OFF)
                @(negedge clk);
            repeat (v_arg[i])
            begin
                check_val("off led", 16'h0, led);
                check_val("off dig", 8'hFF, dig);
                @(negedge clk);
            end
            enable = 1'b1;
        end
        else if (v_op[i] == "rst")
        begin
            repeat (v_arg[i])
                @(negedge clk);
            restart = 1'b1;
            @(negedge clk);
            restart = 1'b0;
        end
        else
        begin
            if (v_op[i] == "flip")
                flip = 7'(v_arg[i]);
            else if (v_op[i] == "rhi")
            begin
                draw_bits(3 - cur_round, flip);
                flip = flip << (4 + cur_round);
            end
            else if (v_op[i] == "rlo")
            begin
                draw_bits(4 + cur_round, flip);
                // an all-zero draw would not be a miss
                if (flip == '0)
                    flip = 7'd1;
            end
            hit = ((flip & width_mask(cur_round)) == 7'd0);
            pulse_start(cur_target ^ flip);
        end
        // a new target is popped unless the guess missed or the game was won
        if (v_stat[i] == "s" && (v_op[i] == "off" || v_op[i] == "rst" || hit))
            take_target();
        cur_round = v_round[i];
        if (v_stat[i] == "p")
            watch_win();
        else
            watch_show();
        if (test_errors == 0)
        begin
            passed++;
            $display("%-18s passed", cur_name);
        end
        else
        begin
            failed++;
            $display("%-18s failed with %0d errors", cur_name, test_errors);
        end
    endtask

    initial
    begin
        int    fd;
        string line;
        string name;
        string op;
        string stat;
        int    arg;
        int    rnd;
        clk         = 1'b0;
        sw          = 1'b1;
        enable      = 1'b0;
        start       = 1'b0;
        restart     = 1'b0;
        guess       = '0;
        ref_lfsr    = `GAME_SEED;
        rnd_lfsr    = 32'h1863bdc1;
        cur_round   = 1;
        passed      = 0;
        failed      = 0;
        cycles      = 0;
        cycle_limit = 0;
        fd = $fopen("dv/game_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open dv/game_vectors.txt");
            failed++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line[0] == "#")
                    continue;
                if ($sscanf(line, "%s %s %h %d %s", name, op, arg, rnd, stat) == 5)
                begin
                    v_name.push_back(name);
                    v_op.push_back(op);
                    v_arg.push_back(arg);
                    v_round.push_back(rnd);
                    v_stat.push_back(stat);
                end
            end
            $fclose(fd);
        end
        cycle_limit = v_name.size() * (`GAME_SHOW_CYCLES + 64);
        repeat (2)
            @(negedge clk);
        sw = 1'b0;
        foreach (v_name[i])
            run_test(i);
        $display("%0d tests passed, %0d failed", passed, failed);
        if (failed == 0 && passed > 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// ==== hw/disp_pkg.sv ====
package disp_pkg;

    // active low segments, bit order dp g f e d c b a
    typedef logic [7:0] seg_t;

    // decimal digits 0 to 9
    localparam seg_t SEG_DIGIT [10] = '{
        8'hC0,
        8'hF9,
        8'hA4,
        8'hB0,
        8'h99,
        8'h92,
        8'h82,
        8'hF8,
        8'h80,
        8'h90
    };

    // status letters
    // S while the target is shown
    localparam seg_t SEG_S = 8'h92;
    // G while waiting for the guess
    localparam seg_t SEG_G = 8'hC2;
    // P once all three rounds are passed
    localparam seg_t SEG_P = 8'h8C;

    // all segments off
    localparam seg_t SEG_BLANK = 8'hFF;

endpackage

// ==== hw/game_defs.svh ====
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// target and led widths
`define GAME_TARGET_W 7
`define GAME_LED_W 16

// 16-bit fibonacci lfsr, must never load zero
`define GAME_LFSR_W 16
`define GAME_SEED 16'hACE1

// target queue depth
`define GAME_FIFO_DEPTH 4

// cycles the target stays on the leds
`define GAME_SHOW_CYCLES 16

// clock cycles per digit in the display scan
`define GAME_SCAN_DIV 4

// led pattern held after round three
`define GAME_WIN_LED 16'hFFFF

`endif

// ==== hw/game_pkg.sv ====
package game_pkg;

    // round controller states
    typedef enum logic [2:0]
    {
        OFF   = 3'd0,
        FETCH = 3'd1,
        SHOW  = 3'd2,
        WAIT  = 3'd3,
        JUDGE = 3'd4,
        WIN   = 3'd5
    } game_state_t;

    // round index, only 1 to 3 are used
    typedef logic [1:0] round_t;

    localparam round_t ROUND_FIRST = 2'd1;
    localparam round_t ROUND_LAST  = 2'd3;

    // round 1 compares 5 bits, round 2 six, round 3 seven

endpackage

// ==== hw/memory_game_top.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module memory_game_top (
    input  logic                      clk,
    input  logic                      sw,
    input  logic                      enable,
    input  logic                      start,
    input  logic                      restart,
    input  logic [`GAME_TARGET_W-1:0] guess,
    output logic [`GAME_LED_W-1:0]    led,
    output disp_pkg::seg_t            seg,
    output logic [7:0]                dig
);

    import game_pkg::*;

    // producer to queue
    logic                      gen_valid;
    logic                      gen_ready;
    logic [`GAME_TARGET_W-1:0] gen_target;

    // queue to round controller
    logic                      q_valid;
    logic                      q_ready;
    logic [`GAME_TARGET_W-1:0] q_target;

    game_state_t state;
    round_t      round;

    target_gen u_target_gen (
        .clk        (clk),
        .sw         (sw),
        .gen_ready  (gen_ready),
        .gen_valid  (gen_valid),
        .gen_target (gen_target)
    );

    target_fifo u_target_fifo (
        .clk        (clk),
        .sw         (sw),
        .gen_valid  (gen_valid),
        .gen_target (gen_target),
        .gen_ready  (gen_ready),
        .q_ready    (q_ready),
        .q_valid    (q_valid),
        .q_target   (q_target)
    );

    round_ctrl u_round_ctrl (
        .clk      (clk),
        .sw       (sw),
        .enable   (enable),
        .start    (start),
        .restart  (restart),
        .guess    (guess),
        .q_valid  (q_valid),
        .q_target (q_target),
        .q_ready  (q_ready),
        .led      (led),
        .state    (state),
        .round    (round)
    );

    seg_scan u_seg_scan (
        .clk   (clk),
        .sw    (sw),
        .state (state),
        .round (round),
        .seg   (seg),
        .dig   (dig)
    );

endmodule

// ==== hw/round_ctrl.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module round_ctrl (
    input  logic                      clk,
    input  logic                      sw,
    input  logic                      enable,
    input  logic                      start,
    input  logic                      restart,
    input  logic [`GAME_TARGET_W-1:0] guess,
    input  logic                      q_valid,
    input  logic [`GAME_TARGET_W-1:0] q_target,
    output logic                      q_ready,
    output logic [`GAME_LED_W-1:0]    led,
    output game_pkg::game_state_t     state,
    output game_pkg::round_t          round
);

    import game_pkg::*;

    localparam int CNT_W = $clog2(`GAME_SHOW_CYCLES);

    game_state_t               next_state;
    logic [`GAME_TARGET_W-1:0] target;
    logic [`GAME_TARGET_W-1:0] mask;
    logic [CNT_W-1:0]          show_cnt;
    logic                      show_done;
    logic                      match;

    // compare width grows by one bit per round
    always_comb
    begin
        case (round)
            2'd1:    mask = 7'h1F;
            2'd2:    mask = 7'h3F;
            default: mask = 7'h7F;
        endcase
    end

    // bits above the round width never count
    assign match = (((guess ^ target) & mask) == '0);

    assign show_done = (show_cnt == '0);

    // pop exactly once, on the FETCH cycle that sees data
    assign q_ready = enable && (state == FETCH) && q_valid;

    always_comb
    begin
        next_state = state;
        if (!enable)
            next_state = OFF;
        else
        begin
            case (state)
                OFF:
                    next_state = FETCH;
                FETCH:
                    if (q_valid)
                        next_state = SHOW;
                SHOW:
                    if (show_done)
                        next_state = WAIT;
                WAIT:
                begin
                    if (restart)
                        next_state = FETCH;
                    else if (start)
                        next_state = JUDGE;
                end
                JUDGE:
                begin
                    // a miss shows the same target again
                    if (!match)
                        next_state = SHOW;
                    else if (round == ROUND_LAST)
                        next_state = WIN;
                    else
                        next_state = FETCH;
                end
                WIN:
                    if (restart)
                        next_state = FETCH;
                default:
                    next_state = OFF;
            endcase
        end
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            state    <= OFF;
            round    <= ROUND_FIRST;
            show_cnt <= '0;
        end
        else
        begin
            state <= next_state;

            // next round after a hit, round one on any other way into FETCH
            if (next_state == FETCH && state != FETCH)
                round <= (state == JUDGE) ? round_t'(round + 2'd1) : ROUND_FIRST;

            // load on entry so SHOW lasts the full window
            if (next_state == SHOW && state != SHOW)
                show_cnt <= CNT_W'(`GAME_SHOW_CYCLES - 1);
            else if (state == SHOW && !show_done)
                show_cnt <= show_cnt - 1'b1;
        end
    end

    // current target, kept across retries
    always_ff @(posedge clk)
    begin
        if (q_ready)
            target <= q_target;
    end

    always_comb
    begin
        case (state)
            SHOW:
                led = {{(`GAME_LED_W - `GAME_TARGET_W){1'b0}}, target & mask};
            WIN:
                led = `GAME_WIN_LED;
            default:
                led = '0;
        endcase
    end

endmodule

// ==== hw/seg_scan.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module seg_scan (
    input  logic                  clk,
    input  logic                  sw,
    input  game_pkg::game_state_t state,
    input  game_pkg::round_t      round,
    output disp_pkg::seg_t        seg,
    output logic [7:0]            dig
);

    import game_pkg::*;
    import disp_pkg::*;

    localparam int DIV_W = $clog2(`GAME_SCAN_DIV);

    logic [DIV_W-1:0] div_cnt;
    logic             sel;
    logic             blank;
    seg_t             letter;

    // sel flips every GAME_SCAN_DIV cycles
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            div_cnt <= '0;
            sel     <= 1'b0;
        end
        else if (div_cnt == DIV_W'(`GAME_SCAN_DIV - 1))
        begin
            div_cnt <= '0;
            sel     <= ~sel;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    // nothing to show while off or fetching
    assign blank = (state == OFF) || (state == FETCH);

    always_comb
    begin
        case (state)
            SHOW:        letter = SEG_S;
            WAIT, JUDGE: letter = SEG_G;
            WIN:         letter = SEG_P;
            default:     letter = SEG_BLANK;
        endcase
    end

    // digit 0 has the round, digit 1 the status letter
    always_comb
    begin
        if (blank)
        begin
            seg = SEG_BLANK;
            dig = 8'hFF;
        end
        else if (!sel)
        begin
            seg = SEG_DIGIT[round];
            dig = 8'b1111_1110;
        end
        else
        begin
            seg = letter;
            dig = 8'b1111_1101;
        end
    end

endmodule

// ==== hw/target_fifo.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module target_fifo (
    input  logic                      clk,
    input  logic                      sw,
    input  logic                      gen_valid,
    input  logic [`GAME_TARGET_W-1:0] gen_target,
    output logic                      gen_ready,
    input  logic                      q_ready,
    output logic                      q_valid,
    output logic [`GAME_TARGET_W-1:0] q_target
);

    localparam int PTR_W = $clog2(`GAME_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`GAME_FIFO_DEPTH + 1);

    logic [`GAME_TARGET_W-1:0] mem [`GAME_FIFO_DEPTH];
    logic [PTR_W-1:0]          wr_ptr;
    logic [PTR_W-1:0]          rd_ptr;
    logic [CNT_W-1:0]          count;
    logic                      push;
    logic                      pop;

    assign gen_ready = (count != CNT_W'(`GAME_FIFO_DEPTH));
    assign q_valid   = (count != '0);

    assign push = gen_valid & gen_ready;
    assign pop  = q_ready & q_valid;

    // head of queue is always presented
    assign q_target = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= gen_target;
    end

    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(`GAME_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(`GAME_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // simultaneous push and pop leaves the count alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== hw/target_gen.sv ====
`timescale 1ns/1ps
`include "game_defs.svh"

module target_gen (
    input  logic                      clk,
    input  logic                      sw,
    input  logic                      gen_ready,
    output logic                      gen_valid,
    output logic [`GAME_TARGET_W-1:0] gen_target
);

    logic [`GAME_LFSR_W-1:0] lfsr;
    logic                    feedback;
    logic                    take;

    // taps 16, 14, 13 and 11, counted from one
    assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    assign take = gen_valid & gen_ready;

    // offer goes up on the first edge out of reset and stays up
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            gen_valid <= 1'b0;
        else
            gen_valid <= 1'b1;
    end

    // step only on an accepted transfer so stalls keep the sequence
    always_ff @(posedge clk or posedge sw)
    begin
        if (sw)
            lfsr <= `GAME_SEED;
        else if (take)
            lfsr <= {lfsr[`GAME_LFSR_W-2:0], feedback};
    end

    assign gen_target = lfsr[`GAME_TARGET_W-1:0];

endmodule
